// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lc4_pipeline
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) --binary -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_lc4_pipeline.sv
module tb_lc4_pipeline;
   import lc4_pkg::*;

   localparam int PERIOD       = 40;
   localparam int RESET_CYCLES = 10;
   localparam int PROG_LEN     = 24;   // words of real program, nops after that
   localparam int MAX_EXP      = 64;

   logic     gwe, i_reset;
   word_t    i_insn, i_dmem_data, o_pc, o_dmem_addr, o_dmem_data;
   logic     o_dmem_we, o_wb_regfile_we, o_wb_nzp_we;
   stall_t   o_wb_stall;
   word_t    o_wb_pc, o_wb_insn, o_wb_regfile_data;
   reg_sel_t o_wb_regfile_wsel;
   nzp_t     o_wb_nzp_bits;

   word_t prog [64];       // instruction memory, offset from RESET_PC
   word_t dmem [256];      // data memory seen by the DUT
   word_t ref_mem [256];   // same memory as the ISA model sees it
   word_t fetch_off;

   // expected retirement stream
   stall_t   exp_stall [MAX_EXP];
   word_t    exp_pc [MAX_EXP], exp_insn [MAX_EXP], exp_data [MAX_EXP];
   logic     exp_we [MAX_EXP], exp_nzp_we [MAX_EXP];
   reg_sel_t exp_wsel [MAX_EXP];
   nzp_t     exp_nzp [MAX_EXP];
   int       n_exp, errors, checks, seed;
   bit       table_ready;

   lc4_pipeline UUT (.*);

   initial begin
      gwe = 1'b0;
      forever #(PERIOD / 2) gwe = ~gwe;
   end

   // both memories answer one cycle after the address
   always @(posedge gwe) begin
      fetch_off = o_pc - RESET_PC;
      i_insn      <= (fetch_off < 16'd64) ? prog[fetch_off[5:0]] : 16'h0000;
      i_dmem_data <= dmem[o_dmem_addr[7:0]];
      if (o_dmem_we)
         dmem[o_dmem_addr[7:0]] <= o_dmem_data;
   end

   function automatic word_t enc_rrr(input logic [3:0] op, input int rd, input int rs,
                                     input logic [2:0] sub, input int rt);
      return {op, 3'(rd), 3'(rs), sub, 3'(rt)};
   endfunction

   function automatic word_t enc_rri(input logic [3:0] op, input int rd, input int rs,
                                     input int imm6);
      return {op, 3'(rd), 3'(rs), 6'(imm6)};
   endfunction

   function automatic word_t enc_ri9(input logic [3:0] op, input int rd, input int imm9);
      return {op, 3'(rd), 9'(imm9)};  // CONST, or BR with rd as the nzp mask
   endfunction

   function automatic nzp_t sign_flags(input word_t v);
      return v[15] ? 3'b100 : (v == 16'h0000) ? 3'b010 : 3'b001;
   endfunction

   // which source registers an instruction reads, per the ISA
   function automatic bit reads_reg(input word_t insn, input reg_sel_t r);
      case (insn[15:12])
         OP_ARITH: return insn[5] ? insn[8:6] == r : (insn[8:6] == r || insn[2:0] == r);
         OP_AND:   return insn[8:6] == r || insn[2:0] == r;
         OP_LDR:   return insn[8:6] == r;
         OP_STR:   return insn[8:6] == r || insn[11:9] == r;
         default:  return 1'b0;
      endcase
   endfunction

   task automatic add_record(input stall_t st, input word_t pc, input word_t insn,
                             input logic we, input reg_sel_t wsel, input word_t data);
      exp_stall[n_exp]  = st;
      exp_pc[n_exp]     = pc;
      exp_insn[n_exp]   = insn;
      exp_we[n_exp]     = we;
      exp_wsel[n_exp]   = wsel;
      exp_data[n_exp]   = data;
      exp_nzp_we[n_exp] = we;   // every register writer in the subset also sets nzp
      exp_nzp[n_exp]    = sign_flags(data);
      n_exp++;
   endtask

   // in-order ISA model, bubbles placed where the hazard rules put them
   task automatic build_expected();
      word_t    regs [8];
      nzp_t     nzp;
      int       pc;
      word_t    insn, v, a;
      reg_sel_t rd, rs, rt, prev_rd;
      logic     we, taken, prev_load;
      for (int i = 0; i < 8; i++)
         regs[i] = 16'h0000;
      nzp = 3'b000;
      pc = 0;
      prev_load = 1'b0;
      prev_rd = 3'd0;
      n_exp = 0;
      while (pc < PROG_LEN) begin
         insn = prog[pc];
         rd = insn[11:9];
         rs = insn[8:6];
         rt = insn[2:0];
         if (prev_load && (reads_reg(insn, prev_rd) || (insn[15:12] == OP_BR && rd != 3'd0)))
            add_record(STALL_LOAD, 16'h0, 16'h0, 1'b0, 3'd0, 16'h0);
         we = 1'b0;
         taken = 1'b0;
         v = 16'h0000;
         case (insn[15:12])
            OP_ARITH: begin
               we = 1'b1;
               if (insn[5])
                  v = regs[rs] + 16'($signed(insn[4:0]));
               else if (insn[5:3] == SUB_SUB)
                  v = regs[rs] - regs[rt];
               else
                  v = regs[rs] + regs[rt];
            end
            OP_AND: begin
               we = 1'b1;
               v = regs[rs] & regs[rt];
            end
            OP_CONST: begin
               we = 1'b1;
               v = 16'($signed(insn[8:0]));
            end
            OP_LDR: begin
               we = 1'b1;
               a = regs[rs] + 16'($signed(insn[5:0]));
               v = ref_mem[a[7:0]];
            end
            OP_STR: begin
               a = regs[rs] + 16'($signed(insn[5:0]));
               ref_mem[a[7:0]] = regs[rd];
            end
            default: taken = |(rd & nzp);   // BR, nzp 000 never taken
         endcase
         add_record(STALL_NONE, RESET_PC + 16'(pc), insn, we, we ? rd : 3'd0, v);
         if (we) begin
            regs[rd] = v;
            nzp = sign_flags(v);
         end
         prev_load = insn[15:12] == OP_LDR;
         prev_rd = rd;
         if (taken) begin
            add_record(STALL_FLUSH, 16'h0, 16'h0, 1'b0, 3'd0, 16'h0);
            add_record(STALL_FLUSH, 16'h0, 16'h0, 1'b0, 3'd0, 16'h0);
            prev_load = 1'b0;
            pc = pc + 1 + int'($signed(insn[8:0]));
         end else begin
            pc = pc + 1;
         end
      end
   endtask

   task automatic check_value(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail time %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   initial begin
      wait (table_ready);
      #(PERIOD * (RESET_CYCLES + n_exp + 20));
      $display("timeout: the retirement stream did not finish in time");
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      i_reset <= 1'b1;
      i_insn <= 16'h0000;
      i_dmem_data <= 16'h0000;
      seed = 5;
      for (int i = 0; i < 256; i++) begin
         ref_mem[i] = 16'($random(seed));
         dmem[i] <= ref_mem[i];
      end
      for (int i = 0; i < 64; i++)
         prog[i] = 16'h0000;   // nop filler
      prog[0]  = enc_ri9(OP_CONST, 1, 5);
      prog[1]  = enc_ri9(OP_CONST, 2, -3);
      prog[2]  = enc_rrr(OP_ARITH, 3, 1, SUB_ADD, 2);  // MX on r2, WX on r1
      prog[3]  = enc_rrr(OP_ARITH, 4, 3, SUB_SUB, 1);
      prog[4]  = enc_rrr(OP_AND, 5, 4, SUB_AND, 3);
      prog[5]  = enc_rri(OP_ARITH, 6, 5, 6'b111111);   // ADD immediate -1
      prog[6]  = enc_ri9(OP_CONST, 7, 16);             // data base address
      prog[7]  = enc_rri(OP_STR, 6, 7, 2);             // store data bypassed
      prog[8]  = enc_rri(OP_LDR, 1, 7, 2);
      prog[9]  = enc_rrr(OP_ARITH, 2, 1, SUB_ADD, 1);  // load-use
      prog[10] = enc_ri9(OP_CONST, 3, 7);
      prog[13] = enc_rrr(OP_ARITH, 4, 3, SUB_ADD, 3);  // write-through read
      prog[14] = enc_rri(OP_LDR, 5, 7, 2);
      prog[15] = enc_ri9(OP_BR, 4, 2);                 // BRn after load, taken
      prog[16] = enc_ri9(OP_CONST, 0, 1);              // skipped
      prog[17] = enc_ri9(OP_CONST, 0, 2);              // skipped
      prog[18] = enc_rri(OP_ARITH, 1, 0, 6'b100000);   // ADD immediate 0, sets z
      prog[19] = enc_ri9(OP_BR, 4, 1);                 // BRn, not taken, stale nzp is n
      prog[20] = enc_ri9(OP_BR, 2, 1);                 // BRz, taken
      prog[21] = enc_ri9(OP_CONST, 2, 9);              // skipped
      prog[22] = enc_rrr(OP_ARITH, 2, 4, SUB_ADD, 3);
      prog[23] = enc_rri(OP_STR, 2, 7, 5);
      build_expected();
      table_ready = 1'b1;
      repeat (RESET_CYCLES) @(posedge gwe);
      i_reset <= 1'b0;
      @(negedge gwe);
      while (o_wb_stall != STALL_NONE) begin   // pipeline still filling
         check_value("o_wb_stall", 16'(o_wb_stall), 16'(STALL_FLUSH));
         check_value("o_wb_regfile_we", 16'(o_wb_regfile_we), 16'h0);
         check_value("o_wb_nzp_we", 16'(o_wb_nzp_we), 16'h0);
         @(negedge gwe);
      end
      $display("test reset: only flush records before the first retirement");
      for (int idx = 0; idx < n_exp; idx++) begin
         check_value("o_wb_stall", 16'(o_wb_stall), 16'(exp_stall[idx]));
         check_value("o_wb_regfile_we", 16'(o_wb_regfile_we), 16'(exp_we[idx]));
         check_value("o_wb_nzp_we", 16'(o_wb_nzp_we), 16'(exp_nzp_we[idx]));
         if (exp_stall[idx] == STALL_NONE) begin
            check_value("o_wb_pc", o_wb_pc, exp_pc[idx]);
            check_value("o_wb_insn", o_wb_insn, exp_insn[idx]);
         end
         if (exp_we[idx]) begin
            check_value("o_wb_regfile_wsel", 16'(o_wb_regfile_wsel), 16'(exp_wsel[idx]));
            check_value("o_wb_regfile_data", o_wb_regfile_data, exp_data[idx]);
            check_value("o_wb_nzp_bits", 16'(o_wb_nzp_bits), 16'(exp_nzp[idx]));
         end
         $display("test %0d: stall %0d pc %h done, errors %0d",
                  idx, exp_stall[idx], exp_pc[idx], errors);
         if (idx < n_exp - 1)
            @(negedge gwe);
      end
      for (int i = 0; i < 256; i++)
         check_value("dmem", dmem[i], ref_mem[i]);
      $display("test memory: data array compared with the model");
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// File: verilog.f
verilog/lc4_pkg.sv
verilog/lc4_bypass_if.sv
verilog/lc4_decoder.sv
verilog/lc4_regfile.sv
verilog/lc4_execute.sv
verilog/lc4_pipeline.sv
test/tb_lc4_pipeline.sv

// File: verilog/lc4_bypass_if.sv
// results of the memory and writeback stages, fed back to execute
interface lc4_bypass_if;
   import lc4_pkg::*;

   logic     m_we;      // memory stage writes a register
   reg_sel_t m_rd;
   word_t    m_data;
   logic     m_nzp_we;
   nzp_t     m_nzp;

   logic     w_we;      // writeback stage writes a register
   reg_sel_t w_rd;
   word_t    w_data;
   logic     w_nzp_we;
   nzp_t     w_nzp;

   modport src  (output m_we, m_rd, m_data, m_nzp_we, m_nzp,
                 output w_we, w_rd, w_data, w_nzp_we, w_nzp);
   modport exec (input  m_we, m_rd, m_data, m_nzp_we, m_nzp,
                 input  w_we, w_rd, w_data, w_nzp_we, w_nzp);
endinterface

// File: verilog/lc4_decoder.sv
module lc4_decoder (
   input  lc4_pkg::word_t    i_insn,
   output lc4_pkg::reg_sel_t o_r1_sel,
   output lc4_pkg::reg_sel_t o_r2_sel,
   output lc4_pkg::reg_sel_t o_rd_sel,
   output logic              o_r1re,
   output logic              o_r2re,
   output logic              o_regfile_we,
   output logic              o_nzp_we,
   output logic              o_is_load,
   output logic              o_is_store,
   output logic              o_is_branch
);
   import lc4_pkg::*;

   logic [3:0] opcode;
   logic [2:0] subop;

   assign opcode = i_insn[15:12];
   assign subop  = i_insn[5:3];

   always_comb begin
      o_r1_sel     = i_insn[8:6];   // rs
      o_r2_sel     = i_insn[2:0];   // rt of reg-reg forms
      o_rd_sel     = i_insn[11:9];  // rd
      // unknown words fall through as harmless no-ops
      o_r1re       = 1'b0;
      o_r2re       = 1'b0;
      o_regfile_we = 1'b0;
      o_nzp_we     = 1'b0;
      o_is_load    = 1'b0;
      o_is_store   = 1'b0;
      o_is_branch  = 1'b0;
      case (opcode)
         OP_ARITH: begin
            if (i_insn[5] || subop == SUB_ADD || subop == SUB_SUB) begin
               o_r1re       = 1'b1;
               o_r2re       = ~i_insn[5];  // immediate form has no rt
               o_regfile_we = 1'b1;
               o_nzp_we     = 1'b1;
            end
         end
         OP_AND: begin
            if (subop == SUB_AND) begin   // reg-reg AND only
               o_r1re       = 1'b1;
               o_r2re       = 1'b1;
               o_regfile_we = 1'b1;
               o_nzp_we     = 1'b1;
            end
         end
         OP_CONST: begin
            o_regfile_we = 1'b1;
            o_nzp_we     = 1'b1;
         end
         OP_LDR: begin
            o_r1re       = 1'b1;   // base register
            o_regfile_we = 1'b1;
            o_nzp_we     = 1'b1;   // LDR sets nzp from the loaded word
            o_is_load    = 1'b1;
         end
         OP_STR: begin
            o_r1re     = 1'b1;
            o_r2re     = 1'b1;
            o_r2_sel   = i_insn[11:9];  // store data lives in the rd field
            o_is_store = 1'b1;
         end
         OP_BR:   o_is_branch = |i_insn[11:9];  // nzp 000 is the nop
         default: ;
      endcase
   end

endmodule

// File: verilog/lc4_execute.sv
module lc4_execute (
   input  lc4_pkg::word_t    i_insn,
   input  lc4_pkg::word_t    i_pc,
   input  lc4_pkg::word_t    i_r1_data,
   input  lc4_pkg::word_t    i_r2_data,
   input  lc4_pkg::reg_sel_t i_r1_sel,
   input  lc4_pkg::reg_sel_t i_r2_sel,
   input  logic              i_r1re,
   input  logic              i_r2re,
   input  logic              i_is_branch,
   input  lc4_pkg::nzp_t     i_nzp_reg,
   lc4_bypass_if.exec        byp,
   output lc4_pkg::word_t    o_result,
   output lc4_pkg::word_t    o_r2_fwd,
   output logic              o_taken
);
   import lc4_pkg::*;

   word_t op1;
   word_t op2;
   word_t imm5;
   word_t imm6;
   word_t imm9;
   nzp_t  nzp_newest;

   // MX beats WX beats the register file value
   assign op1 = (i_r1re && byp.m_we && byp.m_rd == i_r1_sel) ? byp.m_data :
                (i_r1re && byp.w_we && byp.w_rd == i_r1_sel) ? byp.w_data :
                i_r1_data;
   assign op2 = (i_r2re && byp.m_we && byp.m_rd == i_r2_sel) ? byp.m_data :
                (i_r2re && byp.w_we && byp.w_rd == i_r2_sel) ? byp.w_data :
                i_r2_data;

   assign o_r2_fwd = op2;  // store data rides to the memory stage

   // sign-extended immediates
   assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
   assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
   assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

   always_comb begin
      o_result = '0;
      case (i_insn[15:12])
         OP_ARITH: begin
            if (i_insn[5])
               o_result = op1 + imm5;          // ADD immediate
            else if (i_insn[5:3] == SUB_ADD)
               o_result = op1 + op2;
            else if (i_insn[5:3] == SUB_SUB)
               o_result = op1 - op2;
         end
         OP_AND: begin
            if (i_insn[5:3] == SUB_AND)
               o_result = op1 & op2;
         end
         OP_CONST:       o_result = imm9;
         OP_LDR, OP_STR: o_result = op1 + imm6;        // effective address
         OP_BR:          o_result = i_pc + 16'd1 + imm9; // branch target
         default: ;
      endcase
   end

   // the branch must see the nzp of the closest older writer
   assign nzp_newest = byp.m_nzp_we ? byp.m_nzp :
                       byp.w_nzp_we ? byp.w_nzp :
                       i_nzp_reg;

   assign o_taken = i_is_branch && |(i_insn[11:9] & nzp_newest);

endmodule

// File: verilog/lc4_pipeline.sv
module lc4_pipeline (
   input  logic              gwe,
   input  logic              i_reset,
   output lc4_pkg::word_t    o_pc,
   input  lc4_pkg::word_t    i_insn,
   output lc4_pkg::word_t    o_dmem_addr,
   output logic              o_dmem_we,
   output lc4_pkg::word_t    o_dmem_data,
   input  lc4_pkg::word_t    i_dmem_data,
   output lc4_pkg::stall_t   o_wb_stall,
   output lc4_pkg::word_t    o_wb_pc,
   output lc4_pkg::word_t    o_wb_insn,
   output logic              o_wb_regfile_we,
   output lc4_pkg::reg_sel_t o_wb_regfile_wsel,
   output lc4_pkg::word_t    o_wb_regfile_data,
   output logic              o_wb_nzp_we,
   output lc4_pkg::nzp_t     o_wb_nzp_bits
);
   import lc4_pkg::*;

   function automatic nzp_t nzp_of(input word_t v);
      if (v[15])
         return 3'b100;
      else if (v == '0)
         return 3'b010;
      else
         return 3'b001;
   endfunction

   word_t    f_pc;
   word_t    d_pc, d_r1_data, d_r2_data;
   stall_t   d_stall;                  // doubles as the flush-next flop
   reg_sel_t d_r1_sel, d_r2_sel, d_rd_sel;
   logic     d_r1re, d_r2re, d_regfile_we, d_nzp_we, d_is_load, d_is_store, d_is_branch;
   logic     d_go, ld_stall;
   stall_t   x_stall;
   word_t    x_pc, x_insn, x_r1_data, x_r2_data, x_result, x_r2_fwd;
   reg_sel_t x_r1_sel, x_r2_sel, x_rd_sel;
   logic     x_r1re, x_r2re, x_regfile_we, x_nzp_we, x_is_load, x_is_store, x_is_branch;
   logic     x_taken;
   stall_t   m_stall;
   word_t    m_pc, m_insn, m_alu, m_store_data;
   reg_sel_t m_rd_sel;
   logic     m_regfile_we, m_nzp_we, m_is_load, m_is_store;
   stall_t   w_stall;
   word_t    w_pc, w_insn, w_alu, w_data;
   reg_sel_t w_rd_sel;
   logic     w_regfile_we, w_nzp_we, w_is_load;
   nzp_t     w_nzp, nzp_reg;

   lc4_bypass_if byp ();

   // fetch
   assign o_pc = ld_stall ? d_pc : f_pc;  // refetch the held word on a load stall

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         f_pc    <= RESET_PC;
         d_stall <= STALL_FLUSH;
      end else begin
         if (x_taken)
            f_pc <= x_result;               // redirect one cycle late
         else if (!ld_stall)
            f_pc <= f_pc + 16'd1;
         d_stall <= x_taken ? STALL_FLUSH : STALL_NONE;  // wrong-path word arrives next
      end
   end

   always_ff @(posedge gwe) d_pc <= o_pc;  // pc of the word now on i_insn

   // decode works straight off the memory output
   lc4_decoder u_decoder (
      .i_insn(i_insn), .o_r1_sel(d_r1_sel), .o_r2_sel(d_r2_sel), .o_rd_sel(d_rd_sel),
      .o_r1re(d_r1re), .o_r2re(d_r2re), .o_regfile_we(d_regfile_we), .o_nzp_we(d_nzp_we),
      .o_is_load(d_is_load), .o_is_store(d_is_store), .o_is_branch(d_is_branch)
   );

   lc4_regfile u_regfile (
      .gwe(gwe), .i_reset(i_reset),
      .i_rs_sel(d_r1_sel), .i_rt_sel(d_r2_sel),
      .i_rd_sel(w_rd_sel), .i_rd_we(w_regfile_we), .i_rd_data(w_data),
      .o_rs_data(d_r1_data), .o_rt_data(d_r2_data)
   );

   // load in execute, its value only shows up in writeback
   assign ld_stall = x_is_load && d_stall == STALL_NONE &&
                     ((d_r1re && d_r1_sel == x_rd_sel) ||
                      (d_r2re && d_r2_sel == x_rd_sel) || d_is_branch);
   assign d_go = d_stall == STALL_NONE && !x_taken && !ld_stall;

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         x_stall      <= STALL_FLUSH;
         x_r1re       <= 1'b0;
         x_r2re       <= 1'b0;
         x_regfile_we <= 1'b0;
         x_nzp_we     <= 1'b0;
         x_is_load    <= 1'b0;
         x_is_store   <= 1'b0;
         x_is_branch  <= 1'b0;
      end else begin
         x_stall      <= x_taken ? STALL_FLUSH : (ld_stall ? STALL_LOAD : d_stall);
         x_r1re       <= d_go & d_r1re;      // bubbles carry no flags
         x_r2re       <= d_go & d_r2re;
         x_regfile_we <= d_go & d_regfile_we;
         x_nzp_we     <= d_go & d_nzp_we;
         x_is_load    <= d_go & d_is_load;
         x_is_store   <= d_go & d_is_store;
         x_is_branch  <= d_go & d_is_branch;
      end
   end

   always_ff @(posedge gwe) begin
      x_pc      <= d_pc;
      x_insn    <= i_insn;
      x_r1_data <= d_r1_data;
      x_r2_data <= d_r2_data;
      x_r1_sel  <= d_r1_sel;
      x_r2_sel  <= d_r2_sel;
      x_rd_sel  <= d_rd_sel;
   end

   lc4_execute u_execute (
      .i_insn(x_insn), .i_pc(x_pc), .i_r1_data(x_r1_data), .i_r2_data(x_r2_data),
      .i_r1_sel(x_r1_sel), .i_r2_sel(x_r2_sel), .i_r1re(x_r1re), .i_r2re(x_r2re),
      .i_is_branch(x_is_branch), .i_nzp_reg(nzp_reg), .byp(byp),
      .o_result(x_result), .o_r2_fwd(x_r2_fwd), .o_taken(x_taken)
   );

   // memory
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         m_stall      <= STALL_FLUSH;
         m_regfile_we <= 1'b0;
         m_nzp_we     <= 1'b0;
         m_is_load    <= 1'b0;
         m_is_store   <= 1'b0;
      end else begin
         m_stall      <= x_stall;
         m_regfile_we <= x_regfile_we;
         m_nzp_we     <= x_nzp_we;
         m_is_load    <= x_is_load;
         m_is_store   <= x_is_store;
      end
   end

   always_ff @(posedge gwe) begin
      m_pc         <= x_pc;
      m_insn       <= x_insn;
      m_alu        <= x_result;
      m_store_data <= x_r2_fwd;  // already bypassed in execute
      m_rd_sel     <= x_rd_sel;
   end

   assign o_dmem_addr = (m_is_load || m_is_store) ? m_alu : '0;
   assign o_dmem_we   = m_is_store;
   assign o_dmem_data = m_store_data;

   // writeback
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         w_stall      <= STALL_FLUSH;
         w_regfile_we <= 1'b0;
         w_nzp_we     <= 1'b0;
         w_is_load    <= 1'b0;
         nzp_reg      <= '0;
      end else begin
         w_stall      <= m_stall;
         w_regfile_we <= m_regfile_we;
         w_nzp_we     <= m_nzp_we;
         w_is_load    <= m_is_load;
         if (w_nzp_we)
            nzp_reg <= w_nzp;  // architectural nzp
      end
   end

   always_ff @(posedge gwe) begin
      w_pc     <= m_pc;
      w_insn   <= m_insn;
      w_alu    <= m_alu;
      w_rd_sel <= m_rd_sel;
   end

   assign w_data = w_is_load ? i_dmem_data : w_alu;  // load word returns this cycle
   assign w_nzp  = nzp_of(w_data);

   // load results are still in flight while in memory stage
   assign byp.m_we     = m_regfile_we & ~m_is_load;
   assign byp.m_rd     = m_rd_sel;
   assign byp.m_data   = m_alu;
   assign byp.m_nzp_we = m_nzp_we & ~m_is_load;
   assign byp.m_nzp    = nzp_of(m_alu);
   assign byp.w_we     = w_regfile_we;
   assign byp.w_rd     = w_rd_sel;
   assign byp.w_data   = w_data;
   assign byp.w_nzp_we = w_nzp_we;
   assign byp.w_nzp    = w_nzp;

   // trace taken at writeback
   assign o_wb_stall        = w_stall;
   assign o_wb_pc           = w_pc;
   assign o_wb_insn         = w_insn;
   assign o_wb_regfile_we   = w_regfile_we;
   assign o_wb_regfile_wsel = w_rd_sel;
   assign o_wb_regfile_data = w_data;
   assign o_wb_nzp_we       = w_nzp_we;
   assign o_wb_nzp_bits     = w_nzp;

endmodule

// File: verilog/lc4_pkg.sv
package lc4_pkg;

   // widths fixed by the LC4 ISA
   typedef logic [15:0] word_t;     // data, address and instruction word
   typedef logic [2:0]  reg_sel_t;  // register number
   typedef logic [2:0]  nzp_t;      // {n, z, p}
   typedef logic [1:0]  stall_t;    // per-stage stall code seen on the trace

   // stall codes carried down the pipe with every slot
   localparam stall_t STALL_NONE  = 2'd0;  // real instruction
   localparam stall_t STALL_FLUSH = 2'd2;  // reset or squashed by a taken branch
   localparam stall_t STALL_LOAD  = 2'd3;  // bubble inserted behind a load

   localparam word_t RESET_PC = 16'h8200;  // first fetch after reset

   // opcodes in insn[15:12]
   localparam logic [3:0] OP_BR    = 4'h0;
   localparam logic [3:0] OP_ARITH = 4'h1;
   localparam logic [3:0] OP_AND   = 4'h5;
   localparam logic [3:0] OP_LDR   = 4'h6;
   localparam logic [3:0] OP_STR   = 4'h7;
   localparam logic [3:0] OP_CONST = 4'h9;

   // subopcodes in insn[5:3]
   // arith with insn[5] set is ADD immediate
   localparam logic [2:0] SUB_ADD = 3'b000;
   localparam logic [2:0] SUB_SUB = 3'b010;
   localparam logic [2:0] SUB_AND = 3'b000;  // under OP_AND

   localparam int NUM_REGS = 8;

endpackage

// File: verilog/lc4_regfile.sv
module lc4_regfile (
   input  logic              gwe,
   input  logic              i_reset,
   input  lc4_pkg::reg_sel_t i_rs_sel,
   input  lc4_pkg::reg_sel_t i_rt_sel,
   input  lc4_pkg::reg_sel_t i_rd_sel,
   input  logic              i_rd_we,
   input  lc4_pkg::word_t    i_rd_data,
   output lc4_pkg::word_t    o_rs_data,
   output lc4_pkg::word_t    o_rt_data
);
   import lc4_pkg::*;

   word_t regs [NUM_REGS];

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd_sel] <= i_rd_data;
      end
   end

   // write-through so decode sees a value retiring in the same cycle
   assign o_rs_data = (i_rd_we && i_rd_sel == i_rs_sel) ? i_rd_data : regs[i_rs_sel];
   assign o_rt_data = (i_rd_we && i_rd_sel == i_rt_sel) ? i_rd_data : regs[i_rt_sel];

endmodule
